// File: Makefile
# Verilator build and run for the i2c slave testbench

VERILATOR ?= verilator
TOP       ?= tb_i2c_slave
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TESTS PASSED

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass or fail comes from the log
run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
+incdir+include
logic/i2c_slave_pkg.sv
logic/i2c_glitch_filter.sv
logic/i2c_bus_monitor.sv
logic/i2c_slave_fsm.sv
logic/i2c_stuck_timeout.sv
logic/i2c_slave_top.sv
bench/tb_i2c_slave.sv

// File: include/tb_i2c_master.svh
// bit-banged i2c master tasks
`ifndef TB_I2C_MASTER_SVH
`define TB_I2C_MASTER_SVH

// the including bench supplies i_clk and the wired-and bus w_sda_bus
// m_scl and m_sda are the master's open drain drives, 1 = released

localparam int QTR_CLKS = 40;   // clocks per scl quarter period

logic m_scl = 1'b1;
logic m_sda = 1'b1;

// all bus changes land on the falling clock edge
task automatic wait_clks(input int n);
    repeat (n) @(negedge i_clk);
endtask

////////////////////////////////////////////////////////////
// bus conditions
////////////////////////////////////////////////////////////
task automatic i2c_start();
    m_sda = 1'b1;               // safe while scl low, gives repeated start
    wait_clks(QTR_CLKS);
    m_scl = 1'b1;
    wait_clks(QTR_CLKS);
    m_sda = 1'b0;               // start
    wait_clks(QTR_CLKS);
    m_scl = 1'b0;
    wait_clks(QTR_CLKS);
endtask

task automatic i2c_stop();
    m_sda = 1'b0;
    wait_clks(QTR_CLKS);
    m_scl = 1'b1;
    wait_clks(QTR_CLKS);
    m_sda = 1'b1;               // stop
    wait_clks(QTR_CLKS);
endtask

////////////////////////////////////////////////////////////
// single bits, 4 quarters each
////////////////////////////////////////////////////////////
// glitch > 0 adds a short scl high pulse in the low phase
task automatic i2c_send_bit(input logic b, input int glitch);
    m_sda = b;
    wait_clks(QTR_CLKS / 2);
    if (glitch > 0)
    begin
        m_scl = 1'b1;
        wait_clks(glitch);
        m_scl = 1'b0;
    end
    wait_clks(QTR_CLKS / 2 - glitch);
    m_scl = 1'b1;
    wait_clks(2 * QTR_CLKS);
    m_scl = 1'b0;
    wait_clks(QTR_CLKS);
endtask

task automatic i2c_recv_bit(output logic b);
    m_sda = 1'b1;               // let the slave drive
    wait_clks(QTR_CLKS);
    m_scl = 1'b1;
    wait_clks(QTR_CLKS);
    b = w_sda_bus;              // mid scl high
    wait_clks(QTR_CLKS);
    m_scl = 1'b0;
    wait_clks(QTR_CLKS);
endtask

// bit9 is the slave's ninth bit, 0 = ack
task automatic i2c_write_byte(input logic [7:0] data, input int glitch, output logic bit9);
    for (int i = 7; i >= 0; i--)
        i2c_send_bit(data[i], glitch);
    i2c_recv_bit(bit9);
endtask

// ack = 1 asks for another byte
task automatic i2c_read_byte(output logic [7:0] data, input logic ack);
    logic b;
    for (int i = 7; i >= 0; i--)
    begin
        i2c_recv_bit(b);
        data[i] = b;
    end
    i2c_send_bit(~ack, 0);
endtask

`endif

// File: bench/tb_i2c_slave.sv
// i2c slave testbench
module tb_i2c_slave import i2c_slave_pkg::*;;

    localparam i2c_addr_t SLAVE_ADDR = 7'h42;
    localparam i2c_addr_t OTHER_ADDR = 7'h1d;

    logic      i_clk = 1'b0;
    logic      w_rst = 1'b1;
    logic      i_tick_1ms = 1'b0;
    logic      i_scl;
    logic      i_sda;
    logic      i_addr_hit = 1'b0;
    i2c_byte_t i_data_in = '0;
    i2c_addr_t o_addr;
    logic      o_rw;
    i2c_byte_t o_data_out;
    logic      o_data_vld;
    logic      o_start;
    logic      o_stop;
    logic      o_sda_oe;
    logic      o_sda_out;
    wire       w_sda_bus;       // wired-and sda with pull-up

`include "tb_i2c_master.svh"

    // bits per test in 160 clock units plus the timeout ticks
    localparam int TEST_BITS  = 168;
    localparam int TICK_CLKS  = 36 * 8;
    localparam int MAX_CYCLES = (TEST_BITS * 4 * QTR_CLKS + TICK_CLKS) * 3 / 2;

    int        seed = 32'h067e3d8f;
    string     cur_test = "reset";
    int        err_cnt = 0;     // every failed check
    int        err_at_start = 0;
    int        pass_cnt = 0;
    int        fail_cnt = 0;
    int        cycle_cnt = 0;
    int        start_cnt = 0;
    int        stop_cnt = 0;
    int        vld_cnt = 0;
    logic      vld_prev = 1'b0;
    i2c_byte_t wr_q[$];         // bytes seen at o_data_vld

    assign w_sda_bus = m_sda & ~(o_sda_oe & ~o_sda_out);  // slave pulls low only
    assign i_scl     = m_scl;
    assign i_sda     = w_sda_bus;

    i2c_slave_top UUT (
        .i_clk      (i_clk),
        .w_rst      (w_rst),
        .i_tick_1ms (i_tick_1ms),
        .i_scl      (i_scl),
        .i_sda      (i_sda),
        .i_addr_hit (i_addr_hit),
        .i_data_in  (i_data_in),
        .o_addr     (o_addr),
        .o_rw       (o_rw),
        .o_data_out (o_data_out),
        .o_data_vld (o_data_vld),
        .o_start    (o_start),
        .o_stop     (o_stop),
        .o_sda_oe   (o_sda_oe),
        .o_sda_out  (o_sda_out)
    );

    initial
    begin
        forever #10 i_clk = ~i_clk;     // period 20
    end

    ////////////////////////////////////////////////////////////
    // monitors sampled on the falling edge
    ////////////////////////////////////////////////////////////
    always @(negedge i_clk)
    begin
        if (o_start)
            start_cnt++;
        if (o_stop)
            stop_cnt++;
        vld_prev <= o_data_vld;
        if (o_data_vld && !vld_prev)    // rising edge of vld
        begin
            vld_cnt++;
            wr_q.push_back(o_data_out);
        end
        i_addr_hit <= (o_addr == SLAVE_ADDR);  // register map decode
    end

    // run limit
    always @(posedge i_clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    a_no_overlap: assert property (@(posedge i_clk) disable iff (w_rst) !(o_start && o_stop))
    else
    begin
        $display("%s: o_start and o_stop high in the same cycle", cur_test);
        err_cnt++;
    end

    a_start_len: assert property (@(posedge i_clk) disable iff (w_rst) o_start |=> !o_start)
    else
    begin
        $display("%s: o_start held longer than one cycle", cur_test);
        err_cnt++;
    end

    a_stop_len: assert property (@(posedge i_clk) disable iff (w_rst) o_stop |=> !o_stop)
    else
    begin
        $display("%s: o_stop held longer than one cycle", cur_test);
        err_cnt++;
    end

    ////////////////////////////////////////////////////////////
    // check and report helpers
    ////////////////////////////////////////////////////////////
    task automatic begin_test(input string name);
        cur_test     = name;
        err_at_start = err_cnt;
        wr_q.delete();
    endtask

    task automatic end_test();
        int errs;
        errs = err_cnt - err_at_start;
        if (errs == 0)
        begin
            pass_cnt++;
            $display("test %s: ok", cur_test);
        end
        else
        begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", cur_test, errs);
        end
    endtask

    task automatic check_eq(input string what, input i2c_byte_t exp, input i2c_byte_t act);
        assert (act === exp)
        else
        begin
            $display("MISMATCH %s %s expected %02h actual %02h", cur_test, what, exp, act);
            err_cnt++;
        end
    endtask

    // exactly one vld pulse carrying exp
    task automatic check_written(input string what, input i2c_byte_t exp);
        assert (wr_q.size() == 1)
        else
        begin
            $display("MISMATCH %s %s o_data_vld pulses expected 1 actual %0d",
                     cur_test, what, wr_q.size());
            err_cnt++;
        end
        if (wr_q.size() > 0)
            check_eq(what, exp, wr_q.pop_front());
        wr_q.delete();
    endtask

    // start plus address byte and its ninth bit
    task automatic send_addr(input i2c_addr_t addr, input logic rw, output logic ack_bit);
        i2c_start();
        i2c_write_byte({addr, rw}, 0, ack_bit);
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////
    task automatic test_start_stop();
        int s0;
        int p0;
        begin_test("start_stop");
        s0 = start_cnt;
        p0 = stop_cnt;
        i2c_start();
        check_eq("start pulses", 8'd1, 8'(start_cnt - s0));
        check_eq("stop pulses", 8'd0, 8'(stop_cnt - p0));
        i2c_stop();
        wait_clks(10);
        check_eq("start pulses after stop", 8'd1, 8'(start_cnt - s0));
        check_eq("stop pulses after stop", 8'd1, 8'(stop_cnt - p0));
        end_test();
    endtask

    task automatic test_addr_match();
        logic ack_bit;
        int   v0;
        begin_test("addr_match");
        send_addr(SLAVE_ADDR, 1'b0, ack_bit);
        check_eq("o_addr", {1'b0, SLAVE_ADDR}, {1'b0, o_addr});
        check_eq("o_rw", 8'd0, {7'd0, o_rw});
        check_eq("addr ack", 8'd0, {7'd0, ack_bit});
        i2c_stop();
        // foreign address then a byte that nobody takes
        v0 = vld_cnt;
        send_addr(OTHER_ADDR, 1'b0, ack_bit);
        check_eq("addr nack", 8'd1, {7'd0, ack_bit});
        i2c_write_byte(8'h5a, 0, ack_bit);
        check_eq("data nack", 8'd1, {7'd0, ack_bit});
        i2c_stop();
        check_eq("vld pulses", 8'd0, 8'(vld_cnt - v0));
        end_test();
    endtask

    task automatic test_write_bytes();
        logic      ack_bit;
        i2c_byte_t data;
        begin_test("write_bytes");
        send_addr(SLAVE_ADDR, 1'b0, ack_bit);
        check_eq("addr ack", 8'd0, {7'd0, ack_bit});
        wr_q.delete();
        for (int k = 0; k < 3; k++)
        begin
            data = 8'($random(seed));
            i2c_write_byte(data, 0, ack_bit);
            check_eq($sformatf("byte %0d ack", k), 8'd0, {7'd0, ack_bit});
            check_written($sformatf("byte %0d", k), data);
        end
        i2c_stop();
        end_test();
    endtask

    task automatic test_read_bytes();
        logic      ack_bit;
        i2c_byte_t cur;
        i2c_byte_t nxt;
        i2c_byte_t rd;
        begin_test("read_bytes");
        cur       = 8'($random(seed));
        i_data_in = cur;
        send_addr(SLAVE_ADDR, 1'b1, ack_bit);
        check_eq("addr ack", 8'd0, {7'd0, ack_bit});
        check_eq("o_rw", 8'd1, {7'd0, o_rw});
        // two acked bytes and a nacked third
        for (int k = 0; k < 3; k++)
        begin
            nxt = 8'($random(seed));
            fork
                i2c_read_byte(rd, k < 2);
                begin
                    wait_clks(3 * 4 * QTR_CLKS);    // change in mid byte while locked
                    i_data_in = nxt;
                end
            join
            check_eq($sformatf("byte %0d", k), cur, rd);
            cur = nxt;
        end
        i2c_stop();
        end_test();
    endtask

    task automatic test_glitch();
        logic      ack_bit;
        i2c_byte_t data;
        begin_test("glitch");
        send_addr(SLAVE_ADDR, 1'b0, ack_bit);
        check_eq("addr ack", 8'd0, {7'd0, ack_bit});
        wr_q.delete();
        for (int k = 0; k < 2; k++)
        begin
            data = 8'($random(seed));
            i2c_write_byte(data, 2, ack_bit);   // 2 clock scl spikes
            check_eq($sformatf("byte %0d ack", k), 8'd0, {7'd0, ack_bit});
            check_written($sformatf("byte %0d", k), data);
        end
        i2c_stop();
        end_test();
    endtask

    task automatic test_timeout();
        logic      ack_bit;
        i2c_byte_t data;
        begin_test("timeout");
        send_addr(SLAVE_ADDR, 1'b0, ack_bit);
        check_eq("addr ack before", 8'd0, {7'd0, ack_bit});
        check_eq("o_addr before", {1'b0, SLAVE_ADDR}, {1'b0, o_addr});
        m_sda = 1'b0;                   // master holds sda low
        wait_clks(20);
        repeat (36)
        begin
            i_tick_1ms = 1'b1;
            wait_clks(4);
            i_tick_1ms = 1'b0;
            wait_clks(4);
        end
        wait_clks(10);
        check_eq("o_addr after", 8'd0, {1'b0, o_addr});
        // fresh write once the bus is released
        m_sda = 1'b1;
        wait_clks(QTR_CLKS);
        send_addr(SLAVE_ADDR, 1'b0, ack_bit);
        check_eq("addr ack", 8'd0, {7'd0, ack_bit});
        wr_q.delete();
        data = 8'($random(seed));
        i2c_write_byte(data, 0, ack_bit);
        check_eq("data ack", 8'd0, {7'd0, ack_bit});
        check_written("data", data);
        i2c_stop();
        end_test();
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        repeat (5) @(negedge i_clk);
        w_rst = 1'b0;
        wait_clks(20);                  // filters settle on the idle bus
        test_start_stop();
        test_addr_match();
        test_write_bytes();
        test_read_bytes();
        test_glitch();
        test_timeout();
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: logic/i2c_bus_monitor.sv
// i2c bus condition monitor
module i2c_bus_monitor import i2c_slave_pkg::*; #(
    parameter int SDA_DELAY = DEF_SDA_DELAY
) (
    input  logic i_clk,
    input  logic w_rst,
    input  logic i_scl,         // filtered scl
    input  logic i_sda,         // filtered sda
    output logic o_scl_rise,    // scl low to high
    output logic o_scl_fall,    // scl high to low
    output logic o_start,       // sda falls with scl high
    output logic o_stop,        // sda rises with scl high
    output logic o_sda_sample   // sda delayed by SDA_DELAY+1 clocks
);

    logic                 r_scl_prev;   // scl one clock back
    logic                 r_sda_prev;   // sda one clock back
    logic [SDA_DELAY-1:0] r_sda_dly;    // sample delay line
    logic                 w_sda_rise;
    logic                 w_sda_fall;

    ////////////////////////////////////////////////////////////
    // edges against the previous sample
    ////////////////////////////////////////////////////////////
    assign o_scl_rise = ~r_scl_prev & i_scl;
    assign o_scl_fall = r_scl_prev & ~i_scl;
    assign w_sda_rise = ~r_sda_prev & i_sda;
    assign w_sda_fall = r_sda_prev & ~i_sda;

    always_ff @(posedge i_clk or posedge w_rst)
    begin
        if (w_rst)
        begin
            r_scl_prev <= 1'b0;
            r_sda_prev <= 1'b0;
        end
        else
        begin
            r_scl_prev <= i_scl;
            r_sda_prev <= i_sda;
        end
    end

    // start / stop, one clock pulses
    always_ff @(posedge i_clk or posedge w_rst)
    begin
        if (w_rst)
        begin
            o_start <= 1'b0;
            o_stop  <= 1'b0;
        end
        else
        begin
            o_start <= i_scl & w_sda_fall;
            o_stop  <= i_scl & w_sda_rise;  // sda can't rise and fall together
        end
    end

    ////////////////////////////////////////////////////////////
    // delayed sda, sampled by the fsm at scl fall
    ////////////////////////////////////////////////////////////
    // preload to 1 so an idle bus is seen right after reset
    always_ff @(posedge i_clk or posedge w_rst)
    begin
        if (w_rst)
            r_sda_dly <= {SDA_DELAY{1'b1}};
        else
            r_sda_dly <= {r_sda_dly[SDA_DELAY-2:0], r_sda_prev};
    end

    assign o_sda_sample = r_sda_dly[SDA_DELAY-1];  // value from well inside scl high

endmodule

// File: logic/i2c_glitch_filter.sv
// bus line glitch filter
module i2c_glitch_filter import i2c_slave_pkg::*; #(
    parameter int FILTER_STAGES = DEF_FILTER_STAGES
) (
    input  logic i_clk,
    input  logic w_rst,
    input  logic i_line,    // raw scl or sda
    output logic o_line     // filtered level
);

    ////////////////////////////////////////////////////////////
    // sample history, newest bit at position 0
    ////////////////////////////////////////////////////////////
    logic [FILTER_STAGES-1:0] r_hist;

    // output only moves once the whole history agrees
    // so pulses shorter than FILTER_STAGES clocks never pass
    always_ff @(posedge i_clk or posedge w_rst)
    begin
        if (w_rst)
        begin
            r_hist <= {FILTER_STAGES{i_line}};   // start from the live level
            o_line <= 1'b0;
        end
        else
        begin
            r_hist <= {r_hist[FILTER_STAGES-2:0], i_line};
            if (&r_hist)
            begin
                o_line <= 1'b1;     // all high
            end
            else if (~|r_hist)
            begin
                o_line <= 1'b0;     // all low
            end
            // mixed history holds the last level
        end
    end

endmodule

// File: logic/i2c_slave_fsm.sv
// i2c slave byte state machine
module i2c_slave_fsm import i2c_slave_pkg::*; (
    input  logic      i_clk,
    input  logic      w_rst,
    input  logic      i_scl_rise,
    input  logic      i_scl_fall,
    input  logic      i_start,
    input  logic      i_stop,
    input  logic      i_sda_sample,     // delayed bus sda
    input  logic      i_addr_hit,       // external address compare
    input  i2c_byte_t i_data_in,        // read data from the register map
    output i2c_addr_t o_addr,
    output logic      o_rw,             // 1 = master reads
    output i2c_byte_t o_data_out,       // last written byte
    output logic      o_data_vld,
    output logic      o_sda_oe,         // drive enable for the sda pad
    output logic      o_sda_out         // pad value when enabled
);

    i2c_state_e r_state;
    bit_idx_t   r_bit_idx;      // counts 7 down to 0
    i2c_addr_t  r_addr_sh;      // address shifter
    i2c_byte_t  r_rd_byte;      // read byte, frozen while sending
    logic       w_rd_lock;

    ////////////////////////////////////////////////////////////
    // read data lock
    ////////////////////////////////////////////////////////////
    // i_data_in may change under us, hold it for the whole byte
    assign w_rd_lock = (r_state == DATA);

    always_ff @(posedge i_clk or posedge w_rst)
    begin
        if (w_rst)
            r_rd_byte <= DATA_IDLE;
        else if (!w_rd_lock)
            r_rd_byte <= i_data_in;     // track until DATA entry
    end

    // address and write data shifters, msb first
    always_ff @(posedge i_clk)
    begin
        if (i_scl_fall && r_state == ADDR && r_bit_idx != 3'd0)
            r_addr_sh <= {r_addr_sh[5:0], i_sda_sample};
        if (i_scl_fall && r_state == DATA && !o_rw)
            o_data_out <= {o_data_out[6:0], i_sda_sample};
    end

    ////////////////////////////////////////////////////////////
    // main fsm
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or posedge w_rst)
    begin
        if (w_rst)
        begin
            r_state    <= IDLE;
            r_bit_idx  <= '0;
            o_addr     <= '0;
            o_rw       <= 1'b0;
            o_data_vld <= 1'b0;
            o_sda_oe   <= 1'b0;
            o_sda_out  <= 1'b0;
        end
        else if (i_start)
        begin
            r_state <= START_SEEN;      // also repeated start, wins over stop
        end
        else if (i_stop)
        begin
            r_state <= IDLE;
        end
        else
        begin
            case (r_state)
            IDLE:
            begin
                o_addr     <= '0;
                o_data_vld <= 1'b0;
                o_sda_oe   <= 1'b0;
                o_sda_out  <= 1'b0;
            end
            START_SEEN:
            begin
                o_data_vld <= 1'b0;
                o_sda_oe   <= 1'b0;
                if (i_scl_fall)         // end of the start condition
                begin
                    r_state   <= ADDR;
                    r_bit_idx <= 3'd7;
                end
            end
            ADDR:
            begin
                o_sda_oe <= 1'b0;
                if (i_scl_fall)
                begin
                    if (r_bit_idx == 3'd0)
                    begin
                        o_rw    <= i_sda_sample;    // eighth bit is r/w
                        o_addr  <= r_addr_sh;
                        r_state <= ADDR_ACK;
                    end
                    else
                    begin
                        r_bit_idx <= r_bit_idx - 3'd1;
                    end
                end
            end
            ADDR_ACK:
            begin
                o_sda_oe  <= i_addr_hit;    // pull low on a hit only
                o_sda_out <= 1'b0;
                if (i_scl_fall)
                begin
                    r_state   <= i_addr_hit ? DATA : IDLE;
                    r_bit_idx <= 3'd7;
                end
            end
            DATA:
            begin
                // read drives the locked byte, write leaves sda free
                o_sda_oe  <= o_rw;
                o_sda_out <= o_rw & r_rd_byte[r_bit_idx];
                if (i_scl_fall)
                begin
                    r_bit_idx <= r_bit_idx - 3'd1;
                    if (r_bit_idx == 3'd0)
                    begin
                        o_data_vld <= 1'b1;     // byte complete
                        r_state    <= DATA_ACK;
                    end
                end
            end
            DATA_ACK:
            begin
                o_sda_oe  <= ~o_rw;             // ack written bytes
                o_sda_out <= 1'b0;
                if (i_scl_rise)
                    o_data_vld <= 1'b0;
                // master nack on a read parks here until stop / start
                if (i_scl_fall && (!o_rw || !i_sda_sample))
                begin
                    r_state   <= DATA;
                    r_bit_idx <= 3'd7;
                end
            end
            default:
            begin
                r_state    <= IDLE;
                o_data_vld <= 1'b0;
                o_sda_oe   <= 1'b0;
            end
            endcase
        end
    end

endmodule

// File: logic/i2c_slave_pkg.sv
// i2c slave shared types
package i2c_slave_pkg;

    ////////////////////////////////////////////////////////////
    // widths with a meaning
    ////////////////////////////////////////////////////////////
    typedef logic [6:0] i2c_addr_t;     // 7-bit slave address
    typedef logic [7:0] i2c_byte_t;     // one data byte
    typedef logic [2:0] bit_idx_t;      // bit position, msb first
    typedef logic [7:0] ms_cnt_t;       // stuck-bus ms counter

    // byte level fsm states
    typedef enum logic [2:0]
    {
        IDLE,           // bus free or not addressed
        START_SEEN,     // waiting for first scl fall
        ADDR,           // 7 address bits plus r/w
        ADDR_ACK,       // ack or nack of the address
        DATA,           // 8 data bits, read or write
        DATA_ACK        // ninth bit of a data byte
    } i2c_state_e;

    ////////////////////////////////////////////////////////////
    // defaults for the top level parameters
    ////////////////////////////////////////////////////////////
    localparam int DEF_FILTER_STAGES = 3;    // samples that must agree
    localparam int DEF_SDA_DELAY     = 8;    // sda sample delay in clocks
    localparam int DEF_TIMEOUT_MS    = 35;   // sda low limit

    // read byte value before the first load
    localparam i2c_byte_t DATA_IDLE = 8'hff;

endpackage

// File: logic/i2c_slave_top.sv
// i2c slave front end
module i2c_slave_top import i2c_slave_pkg::*; #(
    parameter int FILTER_STAGES = DEF_FILTER_STAGES,
    parameter int SDA_DELAY     = DEF_SDA_DELAY,
    parameter int TIMEOUT_MS    = DEF_TIMEOUT_MS
) (
    input  logic      i_clk,
    input  logic      w_rst,
    input  logic      i_tick_1ms,
    input  logic      i_scl,
    input  logic      i_sda,        // sda as seen at the pad
    input  logic      i_addr_hit,
    input  i2c_byte_t i_data_in,
    output i2c_addr_t o_addr,
    output logic      o_rw,
    output i2c_byte_t o_data_out,
    output logic      o_data_vld,
    output logic      o_start,
    output logic      o_stop,
    output logic      o_sda_oe,     // to the pad ring tristate
    output logic      o_sda_out
);

    logic w_core_rst;
    logic w_timeout_rst;
    logic w_scl_f;
    logic w_sda_f;
    logic w_scl_rise;
    logic w_scl_fall;
    logic w_sda_sample;

    // stuck bus clears everything except the timeout block itself
    assign w_core_rst = w_rst | w_timeout_rst;

    ////////////////////////////////////////////////////////////
    // input conditioning
    ////////////////////////////////////////////////////////////
    i2c_glitch_filter #(.FILTER_STAGES(FILTER_STAGES)) u_scl_filter (
        .i_clk  (i_clk),
        .w_rst  (w_core_rst),
        .i_line (i_scl),
        .o_line (w_scl_f)
    );

    i2c_glitch_filter #(.FILTER_STAGES(FILTER_STAGES)) u_sda_filter (
        .i_clk  (i_clk),
        .w_rst  (w_core_rst),
        .i_line (i_sda),
        .o_line (w_sda_f)
    );

    i2c_bus_monitor #(.SDA_DELAY(SDA_DELAY)) u_bus_monitor (
        .i_clk        (i_clk),
        .w_rst        (w_core_rst),
        .i_scl        (w_scl_f),
        .i_sda        (w_sda_f),
        .o_scl_rise   (w_scl_rise),
        .o_scl_fall   (w_scl_fall),
        .o_start      (o_start),
        .o_stop       (o_stop),
        .o_sda_sample (w_sda_sample)
    );

    ////////////////////////////////////////////////////////////
    // protocol core and timeout
    ////////////////////////////////////////////////////////////
    i2c_slave_fsm u_slave_fsm (
        .i_clk        (i_clk),
        .w_rst        (w_core_rst),
        .i_scl_rise   (w_scl_rise),
        .i_scl_fall   (w_scl_fall),
        .i_start      (o_start),
        .i_stop       (o_stop),
        .i_sda_sample (w_sda_sample),
        .i_addr_hit   (i_addr_hit),
        .i_data_in    (i_data_in),
        .o_addr       (o_addr),
        .o_rw         (o_rw),
        .o_data_out   (o_data_out),
        .o_data_vld   (o_data_vld),
        .o_sda_oe     (o_sda_oe),
        .o_sda_out    (o_sda_out)
    );

    i2c_stuck_timeout #(.TIMEOUT_MS(TIMEOUT_MS)) u_stuck_timeout (
        .i_clk         (i_clk),
        .w_rst         (w_rst),
        .i_tick_1ms    (i_tick_1ms),
        .i_sda_sample  (w_sda_sample),
        .o_timeout_rst (w_timeout_rst)
    );

endmodule

// File: logic/i2c_stuck_timeout.sv
// stuck bus timeout
module i2c_stuck_timeout import i2c_slave_pkg::*; #(
    parameter int TIMEOUT_MS = DEF_TIMEOUT_MS
) (
    input  logic i_clk,
    input  logic w_rst,
    input  logic i_tick_1ms,    // slow tick, async to i_clk
    input  logic i_sda_sample,  // delayed bus sda
    output logic o_timeout_rst  // one clock core reset
);

    localparam ms_cnt_t LIMIT = ms_cnt_t'(TIMEOUT_MS);

    logic    r_tick_0;
    logic    r_tick_1;
    logic    w_tick_rise;
    ms_cnt_t r_ms_cnt;

    ////////////////////////////////////////////////////////////
    // tick sync and edge
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or posedge w_rst)
    begin
        if (w_rst)
        begin
            r_tick_0 <= 1'b1;   // high, no false edge out of reset
            r_tick_1 <= 1'b1;
        end
        else
        begin
            r_tick_0 <= i_tick_1ms;
            r_tick_1 <= r_tick_0;
        end
    end

    assign w_tick_rise = r_tick_0 & ~r_tick_1;

    // count ms while sda stays low
    always_ff @(posedge i_clk or posedge w_rst)
    begin
        if (w_rst)
            r_ms_cnt <= '0;
        else if (i_sda_sample || r_ms_cnt >= LIMIT)
            r_ms_cnt <= '0;
        else if (w_tick_rise)
            r_ms_cnt <= r_ms_cnt + 8'd1;
    end

    always_ff @(posedge i_clk or posedge w_rst)
    begin
        if (w_rst)
            o_timeout_rst <= 1'b0;
        else
            o_timeout_rst <= (r_ms_cnt == LIMIT);   // count clears next clock
    end

endmodule
